/* rtl/memPkg.sv */
package memPkg;

    // the RAM decodes only the low address bits
    localparam int ramAddrBits = 12;

    typedef logic [31:0] memAddr;

    // one port request, count is the byte count minus one
    typedef struct packed {
        memAddr      addr;
        logic        write;
        logic [1:0]  count;
        logic [31:0] wdata;
    } memReq;

    // store responses carry zero data
    typedef struct packed {
        logic [31:0] rdata;
    } memResp;

    // single byte access to the RAM
    typedef struct packed {
        memAddr     addr;
        logic       we;
        logic [7:0] wdata;
    } ramCmd;

endpackage

/* rtl/rvLsuPkg.sv */
package rvLsuPkg;

    typedef enum logic [1:0] {
        lsByte,
        lsHalf,
        lsWord
    } lsWidth;

    // RV32I load funct3 codes
    localparam logic [2:0] LB  = 3'b000;
    localparam logic [2:0] LH  = 3'b001;
    localparam logic [2:0] LW  = 3'b010;
    localparam logic [2:0] LBU = 3'b100;
    localparam logic [2:0] LHU = 3'b101;

    // RV32I store funct3 codes
    localparam logic [2:0] SB = 3'b000;
    localparam logic [2:0] SH = 3'b001;
    localparam logic [2:0] SW = 3'b010;

    typedef struct packed {
        logic        store;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] wdata;
    } lsReq;

    localparam logic [31:0] resetPc = 32'h0000_0000;

endpackage

/* rtl/byteRam.sv */
`timescale 1ns/1ps

module byteRam (
    input  logic          clk,
    input  memPkg::ramCmd cmd,
    output logic [7:0]    rdata
);
    import memPkg::*;

    logic [7:0] mem [0:(1 << ramAddrBits) - 1];
    logic [ramAddrBits-1:0] index;

    // upper address bits wrap onto the array
    assign index = cmd.addr[ramAddrBits-1:0];

    always_ff @(posedge clk) begin
        if (cmd.we) begin
            mem[index] <= cmd.wdata;
        end
        // read is old data on a write to the same byte
        rdata <= mem[index];
    end

endmodule

/* rtl/memCtrl.sv */
`timescale 1ns/1ps

module memCtrl (
    input  logic           clk,
    input  logic           rst,
    input  logic           pause,

    input  memPkg::memReq  fetchReq,
    input  logic           fetchReqValid,
    output logic           fetchReqReady,
    output memPkg::memResp fetchResp,
    output logic           fetchRespValid,
    input  logic           fetchRespReady,

    input  memPkg::memReq  dataReq,
    input  logic           dataReqValid,
    output logic           dataReqReady,
    output memPkg::memResp dataResp,
    output logic           dataRespValid,
    input  logic           dataRespReady,

    output memPkg::ramCmd  ramCmd,
    input  logic [7:0]     ramRdata
);
    import memPkg::*;

    typedef enum logic [2:0] {
        stInit,
        stIdle,
        stIssue,
        stDrain,
        stResp
    } ctrlState;

    ctrlState    state;
    memReq       curReq;
    logic        grantData;
    logic [1:0]  issueCnt;
    logic [1:0]  rdCnt;
    logic        rdPending;
    logic [31:0] word;

    logic idle;
    logic issueNow;
    logic lastIssue;
    logic respValid;
    logic respTaken;

    assign idle = (state == stIdle);

    // data side always wins the grant
    assign dataReqReady  = idle && dataReqValid;
    assign fetchReqReady = idle && !dataReqValid;

    assign issueNow  = (state == stIssue) && !pause;
    assign lastIssue = issueNow && (issueCnt == curReq.count);

    assign respValid      = (state == stResp);
    assign fetchRespValid = respValid && !grantData;
    assign dataRespValid  = respValid && grantData;
    assign respTaken      = respValid && (grantData ? dataRespReady : fetchRespReady);

    assign fetchResp.rdata = word;
    assign dataResp.rdata  = word;

    // one byte per cycle, little endian
    assign ramCmd.addr  = curReq.addr + 32'(issueCnt);
    assign ramCmd.we    = issueNow && curReq.write;
    assign ramCmd.wdata = curReq.wdata[{issueCnt, 3'b000} +: 8];

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stInit;
            grantData <= 1'b0;
            rdPending <= 1'b0;
        end else begin
            // RAM returns the read byte one cycle after issue
            rdPending <= issueNow && !curReq.write;
            case (state)
                stInit: begin
                    state <= stIdle;
                end
                stIdle: begin
                    if (dataReqValid || fetchReqValid) begin
                        state     <= stIssue;
                        grantData <= dataReqValid;
                    end
                end
                stIssue: begin
                    if (lastIssue) begin
                        state <= curReq.write ? stResp : stDrain;
                    end
                end
                stDrain: begin
                    if (rdPending) begin
                        state <= stResp;
                    end
                end
                stResp: begin
                    if (respTaken) begin
                        state <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // request latch and byte assembly
    always_ff @(posedge clk) begin
        if (idle) begin
            curReq   <= dataReqValid ? dataReq : fetchReq;
            issueCnt <= 2'd0;
            rdCnt    <= 2'd0;
            word     <= 32'd0;
        end else begin
            if (issueNow) begin
                issueCnt <= issueCnt + 2'd1;
            end
            if (rdPending) begin
                word[{rdCnt, 3'b000} +: 8] <= ramRdata;
                rdCnt                      <= rdCnt + 2'd1;
            end
        end
    end

endmodule

/* rtl/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit (
    input  logic           clk,
    input  logic           rst,
    input  logic           redirectValid,
    input  memPkg::memAddr redirectPc,
    output logic [31:0]    instr,
    output memPkg::memAddr instrPc,
    output logic           instrValid,
    input  logic           instrReady,
    output memPkg::memReq  memReq,
    output logic           memReqValid,
    input  logic           memReqReady,
    input  memPkg::memResp memResp,
    input  logic           memRespValid,
    output logic           memRespReady
);
    import memPkg::*;
    import rvLsuPkg::*;

    memAddr pc;
    memAddr reqAddr;
    logic   reqPending;
    logic   inFlight;
    logic   drop;
    logic   issue;
    logic   reqHs;
    logic   respHs;

    // pc holds still while the instruction waits
    assign instrPc = pc;

    assign issue  = !reqPending && !inFlight && !instrValid && !redirectValid;
    assign reqHs  = reqPending && memReqReady;
    assign respHs = inFlight && memRespValid;

    assign memReqValid   = reqPending;
    assign memRespReady  = inFlight;
    assign memReq.addr   = reqAddr;
    assign memReq.write  = 1'b0;
    assign memReq.count  = 2'd3;
    assign memReq.wdata  = 32'd0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= resetPc;
            reqPending <= 1'b0;
            inFlight   <= 1'b0;
            drop       <= 1'b0;
            instrValid <= 1'b0;
        end else begin
            if (issue) begin
                reqPending <= 1'b1;
            end else if (reqHs) begin
                reqPending <= 1'b0;
            end
            if (reqHs) begin
                inFlight <= 1'b1;
            end else if (respHs) begin
                inFlight <= 1'b0;
            end
            if (redirectValid) begin
                pc         <= redirectPc;
                instrValid <= 1'b0;
                // anything still outstanding belongs to the old stream
                drop       <= reqPending || (inFlight && !respHs);
            end else if (respHs) begin
                drop       <= 1'b0;
                instrValid <= !drop;
            end else if (instrValid && instrReady) begin
                instrValid <= 1'b0;
                pc         <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            reqAddr <= pc;
        end
        if (respHs) begin
            instr <= memResp.rdata;
        end
    end

endmodule

/* rtl/loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic           clk,
    input  logic           rst,
    input  rvLsuPkg::lsReq req,
    input  logic           reqValid,
    output logic           reqReady,
    output logic [31:0]    loadData,
    output logic           respValid,
    input  logic           respReady,
    output memPkg::memReq  memReq,
    output logic           memReqValid,
    input  logic           memReqReady,
    input  memPkg::memResp memResp,
    input  logic           memRespValid,
    output logic           memRespReady
);
    import rvLsuPkg::*;

    typedef enum logic [1:0] {
        lsIdle,
        lsIssue,
        lsWait,
        lsResp
    } lsuState;

    lsuState     state;
    lsWidth      reqWidth;
    lsWidth      accWidth;
    logic        accUnsigned;
    logic [31:0] extData;

    assign reqReady     = (state == lsIdle);
    assign memReqValid  = (state == lsIssue);
    assign memRespReady = (state == lsWait);
    assign respValid    = (state == lsResp);

    always_comb begin
        if (req.store) begin
            case (req.funct3)
                SB:      reqWidth = lsByte;
                SH:      reqWidth = lsHalf;
                SW:      reqWidth = lsWord;
                default: reqWidth = lsWord;
            endcase
        end else begin
            case (req.funct3)
                LB, LBU: reqWidth = lsByte;
                LH, LHU: reqWidth = lsHalf;
                LW:      reqWidth = lsWord;
                default: reqWidth = lsWord;
            endcase
        end
    end

    // sign or zero fill above the loaded bytes
    always_comb begin
        case (accWidth)
            lsByte:  extData = {{24{memResp.rdata[7] & ~accUnsigned}}, memResp.rdata[7:0]};
            lsHalf:  extData = {{16{memResp.rdata[15] & ~accUnsigned}}, memResp.rdata[15:0]};
            default: extData = memResp.rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= lsIdle;
        end else begin
            case (state)
                lsIdle:  if (reqValid) state <= lsIssue;
                lsIssue: if (memReqReady) state <= lsWait;
                lsWait:  if (memRespValid) state <= lsResp;
                lsResp:  if (respReady) state <= lsIdle;
                default: state <= lsIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reqReady && reqValid) begin
            accWidth     <= reqWidth;
            // LBU and LHU set the top funct3 bit
            accUnsigned  <= !req.store && req.funct3[2];
            memReq.addr  <= req.addr;
            memReq.write <= req.store;
            case (reqWidth)
                lsByte: begin
                    memReq.count <= 2'd0;
                    memReq.wdata <= {24'd0, req.wdata[7:0]};
                end
                lsHalf: begin
                    memReq.count <= 2'd1;
                    memReq.wdata <= {16'd0, req.wdata[15:0]};
                end
                default: begin
                    memReq.count <= 2'd3;
                    memReq.wdata <= req.wdata;
                end
            endcase
        end
        if (memRespReady && memRespValid) begin
            loadData <= extData;
        end
    end

endmodule

/* rtl/memSubsys.sv */
`timescale 1ns/1ps

module memSubsys (
    input  logic           clk,
    input  logic           rst,
    input  logic           pause,

    input  logic           redirectValid,
    input  memPkg::memAddr redirectPc,
    output logic [31:0]    instr,
    output memPkg::memAddr instrPc,
    output logic           instrValid,
    input  logic           instrReady,

    input  rvLsuPkg::lsReq lsReq,
    input  logic           lsReqValid,
    output logic           lsReqReady,
    output logic [31:0]    loadData,
    output logic           loadValid,
    input  logic           loadReady
);
    import memPkg::*;

    memReq      fetchReq;
    memReq      dataReq;
    memResp     fetchResp;
    memResp     dataResp;
    ramCmd      ramBus;
    logic [7:0] ramRdata;
    logic       fetchReqValid;
    logic       fetchReqReady;
    logic       fetchRespValid;
    logic       fetchRespReady;
    logic       dataReqValid;
    logic       dataReqReady;
    logic       dataRespValid;
    logic       dataRespReady;

    fetchUnit fetch (
        .clk          (clk),
        .rst          (rst),
        .redirectValid(redirectValid),
        .redirectPc   (redirectPc),
        .instr        (instr),
        .instrPc      (instrPc),
        .instrValid   (instrValid),
        .instrReady   (instrReady),
        .memReq       (fetchReq),
        .memReqValid  (fetchReqValid),
        .memReqReady  (fetchReqReady),
        .memResp      (fetchResp),
        .memRespValid (fetchRespValid),
        .memRespReady (fetchRespReady)
    );

    loadStoreUnit lsu (
        .clk         (clk),
        .rst         (rst),
        .req         (lsReq),
        .reqValid    (lsReqValid),
        .reqReady    (lsReqReady),
        .loadData    (loadData),
        .respValid   (loadValid),
        .respReady   (loadReady),
        .memReq      (dataReq),
        .memReqValid (dataReqValid),
        .memReqReady (dataReqReady),
        .memResp     (dataResp),
        .memRespValid(dataRespValid),
        .memRespReady(dataRespReady)
    );

    memCtrl ctrl (
        .clk           (clk),
        .rst           (rst),
        .pause         (pause),
        .fetchReq      (fetchReq),
        .fetchReqValid (fetchReqValid),
        .fetchReqReady (fetchReqReady),
        .fetchResp     (fetchResp),
        .fetchRespValid(fetchRespValid),
        .fetchRespReady(fetchRespReady),
        .dataReq       (dataReq),
        .dataReqValid  (dataReqValid),
        .dataReqReady  (dataReqReady),
        .dataResp      (dataResp),
        .dataRespValid (dataRespValid),
        .dataRespReady (dataRespReady),
        .ramCmd        (ramBus),
        .ramRdata      (ramRdata)
    );

    byteRam ram (
        .clk  (clk),
        .cmd  (ramBus),
        .rdata(ramRdata)
    );

endmodule

/* sim/memCtrlAssertions.sv */
`timescale 1ns/1ps

module memCtrlAssertions (
    input logic           clk,
    input logic           rst,
    input logic           pause,
    input logic           fetchReqValid,
    input logic           fetchReqReady,
    input logic           dataReqValid,
    input logic           dataReqReady,
    input memPkg::memResp fetchResp,
    input logic           fetchRespValid,
    input logic           fetchRespReady,
    input memPkg::memResp dataResp,
    input logic           dataRespValid,
    input logic           dataRespReady,
    input memPkg::ramCmd  ramCmd
);

    // a granted request closes both ports in the following cycle
    singleGrant: assert property (@(posedge clk) disable iff (rst)
        ((fetchReqValid && fetchReqReady) || (dataReqValid && dataReqReady))
        |=> !fetchReqReady && !dataReqReady)
        else $error("a port was ready again right after a grant");

    fetchRespHold: assert property (@(posedge clk) disable iff (rst)
        fetchRespValid && !fetchRespReady |=> fetchRespValid && $stable(fetchResp))
        else $error("fetch response dropped or changed before it was taken");

    dataRespHold: assert property (@(posedge clk) disable iff (rst)
        dataRespValid && !dataRespReady |=> dataRespValid && $stable(dataResp))
        else $error("data response dropped or changed before it was taken");

    // a pause between store bytes writes nothing and holds the byte address
    noWriteOnPause: assert property (@(posedge clk) disable iff (rst)
        pause && $past(ramCmd.we) |=> !$past(ramCmd.we) && $stable(ramCmd.addr))
        else $error("RAM write or byte address step while paused");

endmodule

/* sim/memSubsysTb.sv */
`timescale 1ns/1ps

module memSubsysTb;
    import memPkg::*;
    import rvLsuPkg::*;

    localparam int waitLimit = 300;

    logic        clk;
    logic        rst;
    logic        pause;
    logic        redirectValid;
    memAddr      redirectPc;
    logic [31:0] instr;
    memAddr      instrPc;
    logic        instrValid;
    logic        instrReady;
    lsReq        lsRequest;
    logic        lsReqValid;
    logic        lsReqReady;
    logic [31:0] loadData;
    logic        loadValid;
    logic        loadReady;

    int    seed;
    int    errors;
    int    testMark;
    int    testsRun;
    int    testsFailed;
    string curTest;

    // expected contents of the byte RAM
    logic [7:0] model [0:(1 << ramAddrBits) - 1];

    memSubsys UUT (
        .lsReq(lsRequest),
        .*
    );

    bind memCtrl memCtrlAssertions checks (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [7:0] modelByte(memAddr addr, int k);
        return model[ramAddrBits'(addr + k)];
    endfunction

    // RV32I load rules applied to the model
    function automatic logic [31:0] modelLoad(logic [2:0] f3, memAddr addr);
        logic [7:0] b0;
        logic [7:0] b1;
        b0 = modelByte(addr, 0);
        b1 = modelByte(addr, 1);
        case (f3)
            LB:      return {{24{b0[7]}}, b0};
            LH:      return {{16{b1[7]}}, b1, b0};
            LBU:     return {24'd0, b0};
            LHU:     return {16'd0, b1, b0};
            default: return {modelByte(addr, 3), modelByte(addr, 2), b1, b0};
        endcase
    endfunction

    // upper half of the RAM, clear of the fetch areas
    function automatic memAddr randAddr();
        return 32'h800 | ($random(seed) & 32'h7ff);
    endfunction

    task automatic openTest(string name);
        curTest  = name;
        testMark = errors;
    endtask

    task automatic closeTest();
        testsRun++;
        if (errors == testMark) begin
            $display("test %s passed", curTest);
        end else begin
            testsFailed++;
            $display("test %s failed with %0d errors", curTest, errors - testMark);
        end
    endtask

    // one request through the load/store unit, response held for hold cycles
    task automatic lsAccess(logic store, logic [2:0] f3, memAddr addr, logic [31:0] wdata,
                            int hold, output logic [31:0] rdata);
        int   t;
        logic took;
        rdata = 'x;
        @(posedge clk);
        lsRequest  <= '{store, f3, addr, wdata};
        lsReqValid <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!lsReqReady && t < waitLimit);
        took = lsReqReady;
        @(posedge clk);
        lsReqValid <= 1'b0;
        if (!took) begin
            errors++;
            $display("%s: load/store unit never took the request", curTest);
            return;
        end
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!loadValid && t < waitLimit);
        if (!loadValid) begin
            errors++;
            $display("%s: timed out waiting for the load/store response", curTest);
            return;
        end
        rdata = loadData;
        repeat (hold) begin
            @(negedge clk);
            if (!loadValid || loadData !== rdata) begin
                errors++;
                $display("%s: response changed before it was accepted", curTest);
            end
        end
        @(posedge clk);
        loadReady <= 1'b1;
        @(posedge clk);
        loadReady <= 1'b0;
    endtask

    task automatic storeOp(logic [2:0] f3, memAddr addr, logic [31:0] data, int hold);
        logic [31:0] resp;
        int          n;
        int          k;
        n = (f3 == SB) ? 1 : (f3 == SH) ? 2 : 4;
        for (k = 0; k < n; k++) begin
            model[ramAddrBits'(addr + k)] = 8'(data >> (8 * k));
        end
        lsAccess(1'b1, f3, addr, data, hold, resp);
        if (resp !== 32'd0) begin
            errors++;
            $display("Mismatch in %s store at %h: expected %h, actual %h",
                     curTest, addr, 32'd0, resp);
        end
    endtask

    task automatic loadCheck(logic [2:0] f3, memAddr addr, logic [31:0] expected, int hold);
        logic [31:0] resp;
        lsAccess(1'b0, f3, addr, 32'd0, hold, resp);
        if (resp !== expected) begin
            errors++;
            $display("Mismatch in %s load at %h: expected %h, actual %h",
                     curTest, addr, expected, resp);
        end
    endtask

    task automatic takeInstr(memAddr expPc);
        int          t;
        logic [31:0] expInstr;
        expInstr = {modelByte(expPc, 3), modelByte(expPc, 2),
                    modelByte(expPc, 1), modelByte(expPc, 0)};
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!instrValid && t < waitLimit);
        if (!instrValid) begin
            errors++;
            $display("%s: timed out waiting for an instruction", curTest);
            return;
        end
        if (instrPc !== expPc) begin
            errors++;
            $display("Mismatch in %s instrPc: expected %h, actual %h", curTest, expPc, instrPc);
        end
        if (instr !== expInstr) begin
            errors++;
            $display("Mismatch in %s instr: expected %h, actual %h", curTest, expInstr, instr);
        end
        @(posedge clk);
        instrReady <= 1'b1;
        @(posedge clk);
        instrReady <= 1'b0;
    endtask

    task automatic redirectTo(memAddr target);
        @(posedge clk);
        redirectValid <= 1'b1;
        redirectPc    <= target;
        @(posedge clk);
        redirectValid <= 1'b0;
    endtask

    task automatic storeLoadTest();
        memAddr      addr;
        logic [31:0] data;
        int          i;
        openTest("store_load");
        for (i = 0; i < 4; i++) begin
            addr = randAddr();
            data = $random(seed);
            storeOp(SW, addr, data, 0);
            loadCheck(LW, addr, data, 0);
            addr = randAddr();
            data = $random(seed);
            storeOp(SB, addr, data, 0);
            loadCheck(LBU, addr, {24'd0, data[7:0]}, 0);
            addr = randAddr();
            data = $random(seed);
            storeOp(SH, addr, data, 0);
            loadCheck(LHU, addr, {16'd0, data[15:0]}, 0);
        end
        closeTest();
    endtask

    task automatic signExtendTest();
        openTest("sign_extend");
        storeOp(SB, 32'h40, 32'h80, 0);
        storeOp(SH, 32'h42, 32'h8001, 0);
        loadCheck(LB, 32'h40, 32'hffffff80, 0);
        loadCheck(LBU, 32'h40, 32'h00000080, 0);
        loadCheck(LH, 32'h42, 32'hffff8001, 0);
        loadCheck(LHU, 32'h42, 32'h00008001, 0);
        closeTest();
    endtask

    task automatic fetchTest();
        int i;
        openTest("fetch");
        for (i = 0; i < 4; i++) begin
            storeOp(SW, 32'h100 + 4 * i, $random(seed), 0);
        end
        redirectTo(32'h100);
        for (i = 0; i < 4; i++) begin
            takeInstr(32'h100 + 4 * i);
        end
        closeTest();
    endtask

    task automatic priorityTest();
        int i;
        int j;
        int k;
        openTest("priority_redirect");
        for (i = 0; i < 8; i++) begin
            storeOp(SW, 32'h200 + 4 * i, $random(seed), 0);
        end
        redirectTo(32'h200);
        fork
            begin
                for (j = 0; j < 4; j++) begin
                    takeInstr(32'h200 + 4 * j);
                end
            end
            begin
                for (k = 0; k < 4; k++) begin
                    loadCheck(LW, 32'h200 + 4 * k, modelLoad(LW, 32'h200 + 4 * k), 0);
                end
            end
        join
        // next fetch is already on its way here
        redirectTo(32'h218);
        takeInstr(32'h218);
        takeInstr(32'h21c);
        closeTest();
    endtask

    task automatic pauseTest();
        logic [63:0] pattern;
        memAddr      addr;
        logic [31:0] data;
        logic        opsDone;
        int          c;
        int          i;
        openTest("pause_backpressure");
        pattern = {$random(seed), $random(seed)};
        opsDone = 1'b0;
        fork
            begin
                c = 0;
                while (!opsDone && c < 20 * waitLimit) begin
                    @(posedge clk);
                    pause <= pattern[c[5:0]];
                    c++;
                end
                pause <= 1'b0;
            end
            begin
                for (i = 0; i < 3; i++) begin
                    addr = randAddr();
                    data = $random(seed);
                    storeOp(SW, addr, data, 3 + i);
                    loadCheck(LW, addr, data, 4);
                    loadCheck(LH, addr, modelLoad(LH, addr), 2);
                end
                opsDone = 1'b1;
            end
        join
        closeTest();
    endtask

    initial begin
        seed          = 32'ha7442053;
        errors        = 0;
        testMark      = 0;
        testsRun      = 0;
        testsFailed   = 0;
        rst           = 1'b1;
        pause         = 1'b0;
        redirectValid = 1'b0;
        redirectPc    = '0;
        instrReady    = 1'b0;
        lsRequest     = '0;
        lsReqValid    = 1'b0;
        loadReady     = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        storeLoadTest();
        signExtendTest();
        fetchTest();
        priorityTest();
        pauseTest();
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/memPkg.sv
rtl/rvLsuPkg.sv
rtl/byteRam.sv
rtl/memCtrl.sv
rtl/fetchUnit.sv
rtl/loadStoreUnit.sv
rtl/memSubsys.sv
sim/memCtrlAssertions.sv
sim/memSubsysTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= memSubsysTb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

SIM_BIN = $(BUILD_DIR)/V$(TOP)
SOURCES = $(wildcard rtl/*.sv sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
